//--- all.f
logic/rv_pkg.sv
logic/decoder.sv
logic/regfile.sv
logic/map_table.sv
logic/operand_read.sv
logic/dispatch_ctrl.sv
logic/issue_stage.sv
bench/tb_clock.sv
bench/issue_stage_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the issue stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module issue_stage_tb -f all.f -Mdir obj_dir -o issue_stage_sim; then
	echo "compile failed"
	exit 1
fi

./obj_dir/issue_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
	exit 0
fi
exit 1

//--- bench/issue_stage_tb.sv
`timescale 1ns/10ps

module issue_stage_tb import rv_pkg::*; ();

	localparam int TAG_W      = DEF_TAG_W;
	localparam int NUM_CYCLES = 2000;
	localparam int LIMIT      = NUM_CYCLES + 2 + 50;

	logic clock, reset;
	inst_t inst;
	logic inst_valid;
	xlen_t pc;
	logic rob_full;
	logic [TAG_W-1:0] rob_tail_tag;
	xlen_t rs1_rob_value, rs2_rob_value;
	logic [1:0] rs_full;
	logic cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	logic commit_en;
	reg_idx_t commit_idx;
	xlen_t commit_data;
	logic [TAG_W-1:0] commit_tag;
	opa_sel_t opa_select;
	opb_sel_t opb_select;
	alu_func_t alu_func;
	logic has_dest, rd_mem, wr_mem, cond_branch, uncond_branch, csr_op;
	logic halt, illegal, decoded_valid;
	xlen_t dispatch_pc;
	xlen_t rs1_value, rs2_value;
	logic rs1_ready, rs2_ready;
	logic [TAG_W-1:0] rs1_tag, rs2_tag;
	fu_sel_t fu_select;
	logic dispatch_en, stall_if, alloc_wr_mem, rename_en;
	logic [TAG_W-1:0] alloc_tag, rename_tag;
	funct3_t alloc_mem_size;
	reg_idx_t rename_idx;

	// expected decode for the instruction currently driven
	opa_sel_t d_opa;
	opb_sel_t d_opb;
	alu_func_t d_alu;
	logic d_dest, d_rdm, d_wrm, d_cbr, d_ubr, d_csr, d_halt, d_ill;

	// shadow register file and map table
	xlen_t m_rf [32];
	logic m_busy [32];
	logic m_ready [32];
	logic [TAG_W-1:0] m_tag [32];

	logic [31:0] seed = 32'h7895;
	int cycles = 0;

	tb_clock clk_gen (.clock(clock), .reset(reset));

	issue_stage #(.TAG_W(TAG_W)) dut (.*);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return {8'h00, seed[31:8]};
	endfunction

	// what the ROB holds for a finished tag
	function automatic xlen_t rob_value(input logic [TAG_W-1:0] t);
		return 32'hc0de0000 ^ (xlen_t'(t) * 32'h01010101);
	endfunction

	assign rs1_rob_value = rob_value(rs1_tag);  // ROB answers the tag it is shown
	assign rs2_rob_value = rob_value(rs2_tag);

	// reference model outputs
	reg_idx_t s1, s2, rd_f;
	fu_sel_t exp_class;
	logic class_full, exp_valid, exp_dispatch, exp_stall, exp_rename;
	logic exp_rs1_ready, exp_rs2_ready;
	xlen_t exp_rs1_value, exp_rs2_value;

	always_comb begin
		s1            = inst[19:15];
		s2            = inst[24:20];
		rd_f          = inst[11:7];
		exp_class     = (d_rdm || d_wrm) ? FU_ACU : FU_ALU;
		class_full    = (exp_class == FU_ACU) ? rs_full[1] : rs_full[0];
		exp_valid     = inst_valid && !d_halt && !d_ill;
		exp_dispatch  = exp_valid && !rob_full && !class_full;
		exp_stall     = exp_valid && (rob_full || class_full);
		exp_rename    = exp_dispatch && d_dest && rd_f != 5'd0;
		exp_rs1_ready = !m_busy[s1] || m_ready[s1];
		exp_rs2_ready = !m_busy[s2] || m_ready[s2];
		exp_rs1_value = m_busy[s1] ? rob_value(m_tag[s1]) : m_rf[s1];
		exp_rs2_value = m_busy[s2] ? rob_value(m_tag[s2]) : m_rf[s2];
	end

	initial begin
		for (int i = 0; i < 32; i++)
			m_rf[i] = '0;
	end

	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				m_busy[i]  <= 1'b0;
				m_ready[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 32; i++) begin
				if (cdb_valid && m_busy[i] && m_tag[i] == cdb_tag)
					m_ready[i] <= 1'b1;
				if (commit_en && commit_idx == i[4:0] && m_busy[i] && m_tag[i] == commit_tag)
					m_busy[i] <= 1'b0;
			end
			if (exp_rename) begin  // rename overrides wakeup and clear
				m_busy[rd_f]  <= 1'b1;
				m_ready[rd_f] <= 1'b0;
				m_tag[rd_f]   <= rob_tail_tag;
			end
		end
		if (commit_en && commit_idx != 5'd0)
			m_rf[commit_idx] <= commit_data;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		$display("Simulation FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	assert property (@(posedge clock) disable iff (reset) dispatch_en == exp_dispatch)
		else report_mismatch("dispatch_en", $sampled(dispatch_en), $sampled(exp_dispatch));
	assert property (@(posedge clock) disable iff (reset) stall_if == exp_stall)
		else report_mismatch("stall_if", $sampled(stall_if), $sampled(exp_stall));
	assert property (@(posedge clock) disable iff (reset)
		fu_select == (exp_dispatch ? exp_class : FU_NONE))
		else report_mismatch("fu_select", $sampled(fu_select),
			$sampled(exp_dispatch ? exp_class : FU_NONE));
	assert property (@(posedge clock) disable iff (reset) decoded_valid == exp_valid)
		else report_mismatch("decoded_valid", $sampled(decoded_valid), $sampled(exp_valid));
	assert property (@(posedge clock) disable iff (reset) halt == (inst_valid && d_halt))
		else report_mismatch("halt", $sampled(halt), $sampled(inst_valid && d_halt));
	assert property (@(posedge clock) disable iff (reset) illegal == (inst_valid && d_ill))
		else report_mismatch("illegal", $sampled(illegal), $sampled(inst_valid && d_ill));
	assert property (@(posedge clock) disable iff (reset) inst_valid |-> opa_select == d_opa)
		else report_mismatch("opa_select", $sampled(opa_select), $sampled(d_opa));
	assert property (@(posedge clock) disable iff (reset) inst_valid |-> opb_select == d_opb)
		else report_mismatch("opb_select", $sampled(opb_select), $sampled(d_opb));
	assert property (@(posedge clock) disable iff (reset) inst_valid |-> alu_func == d_alu)
		else report_mismatch("alu_func", $sampled(alu_func), $sampled(d_alu));
	assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> {has_dest, rd_mem, wr_mem} == {d_dest, d_rdm, d_wrm})
		else report_mismatch("has_dest/rd_mem/wr_mem", $sampled({has_dest, rd_mem, wr_mem}),
			$sampled({d_dest, d_rdm, d_wrm}));
	assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> {cond_branch, uncond_branch, csr_op} == {d_cbr, d_ubr, d_csr})
		else report_mismatch("cond_branch/uncond_branch/csr_op",
			$sampled({cond_branch, uncond_branch, csr_op}), $sampled({d_cbr, d_ubr, d_csr}));
	assert property (@(posedge clock) disable iff (reset) dispatch_pc == pc)
		else report_mismatch("dispatch_pc", $sampled(dispatch_pc), $sampled(pc));
	assert property (@(posedge clock) disable iff (reset) alloc_tag == rob_tail_tag)
		else report_mismatch("alloc_tag", $sampled(alloc_tag), $sampled(rob_tail_tag));
	assert property (@(posedge clock) disable iff (reset)
		dispatch_en |-> alloc_mem_size == inst[14:12])
		else report_mismatch("alloc_mem_size", $sampled(alloc_mem_size), $sampled(inst[14:12]));
	assert property (@(posedge clock) disable iff (reset)
		exp_dispatch |-> alloc_wr_mem == d_wrm)
		else report_mismatch("alloc_wr_mem", $sampled(alloc_wr_mem), $sampled(d_wrm));
	assert property (@(posedge clock) disable iff (reset) rename_en == exp_rename)
		else report_mismatch("rename_en", $sampled(rename_en), $sampled(exp_rename));
	assert property (@(posedge clock) disable iff (reset) exp_rename |-> rename_idx == rd_f)
		else report_mismatch("rename_idx", $sampled(rename_idx), $sampled(rd_f));
	assert property (@(posedge clock) disable iff (reset)
		exp_rename |-> rename_tag == rob_tail_tag)
		else report_mismatch("rename_tag", $sampled(rename_tag), $sampled(rob_tail_tag));
	assert property (@(posedge clock) disable iff (reset) rs1_ready == exp_rs1_ready)
		else report_mismatch("rs1_ready", $sampled(rs1_ready), $sampled(exp_rs1_ready));
	assert property (@(posedge clock) disable iff (reset) rs2_ready == exp_rs2_ready)
		else report_mismatch("rs2_ready", $sampled(rs2_ready), $sampled(exp_rs2_ready));
	assert property (@(posedge clock) disable iff (reset) !exp_rs1_ready |-> rs1_tag == m_tag[s1])
		else report_mismatch("rs1_tag", $sampled(rs1_tag), $sampled(m_tag[s1]));
	assert property (@(posedge clock) disable iff (reset) !exp_rs2_ready |-> rs2_tag == m_tag[s2])
		else report_mismatch("rs2_tag", $sampled(rs2_tag), $sampled(m_tag[s2]));
	assert property (@(posedge clock) disable iff (reset)
		exp_rs1_ready |-> rs1_value == exp_rs1_value)
		else report_mismatch("rs1_value", $sampled(rs1_value), $sampled(exp_rs1_value));
	assert property (@(posedge clock) disable iff (reset)
		exp_rs2_ready |-> rs2_value == exp_rs2_value)
		else report_mismatch("rs2_value", $sampled(rs2_value), $sampled(exp_rs2_value));

	// integer op table shared by OP_IMM and OP_REG
	task automatic pick_int_op(input int sel, output funct3_t f3, output funct7_t f7,
	                           output alu_func_t alu);
		f7 = F7_BASE;
		case (sel)
			0: begin f3 = F3_ADD;  alu = ALU_ADD;  end
			1: begin f3 = F3_SLL;  alu = ALU_SLL;  end
			2: begin f3 = F3_SLT;  alu = ALU_SLT;  end
			3: begin f3 = F3_SLTU; alu = ALU_SLTU; end
			4: begin f3 = F3_XOR;  alu = ALU_XOR;  end
			5: begin f3 = F3_SR;   alu = ALU_SRL;  end
			6: begin f3 = F3_SR;   alu = ALU_SRA;  f7 = F7_ALT; end
			7: begin f3 = F3_OR;   alu = ALU_OR;   end
			8: begin f3 = F3_AND;  alu = ALU_AND;  end
			9: begin f3 = F3_ADD;  alu = ALU_SUB;  f7 = F7_ALT; end
			10: begin f3 = F3_MUL;    alu = ALU_MUL;    f7 = F7_MULDIV; end
			11: begin f3 = F3_MULH;   alu = ALU_MULH;   f7 = F7_MULDIV; end
			12: begin f3 = F3_MULHSU; alu = ALU_MULHSU; f7 = F7_MULDIV; end
			default: begin f3 = F3_MULHU; alu = ALU_MULHU; f7 = F7_MULDIV; end
		endcase
	endtask

	task automatic build_inst();
		logic [31:0] r;
		logic [31:0] imm;
		reg_idx_t rd_n, rs1_n, rs2_n;
		funct3_t f3;
		funct7_t f7;
		funct3_t br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		funct3_t ld_f3 [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
		funct3_t st_f3 [3] = '{F3_SB, F3_SH, F3_SW};
		funct3_t csr_f3 [3] = '{F3_CSRRW, F3_CSRRS, F3_CSRRC};
		r = next_rand();
		imm = next_rand();
		rd_n = {2'b00, r[2:0]};  // x0..x7 so that renames collide often
		rs1_n = {2'b00, r[5:3]};
		rs2_n = {2'b00, r[8:6]};
		d_opa = OPA_IS_RS1;
		d_opb = OPB_IS_RS2;
		d_alu = ALU_ADD;
		{d_dest, d_rdm, d_wrm, d_cbr, d_ubr, d_csr, d_halt, d_ill} = '0;
		case (next_rand() % 13)
			0: begin
				inst = {imm[31:12], rd_n, OP_LUI};
				d_dest = 1'b1;
				d_opa = OPA_IS_ZERO;
				d_opb = OPB_IS_U_IMM;
			end
			1: begin
				inst = {imm[31:12], rd_n, OP_AUIPC};
				d_dest = 1'b1;
				d_opa = OPA_IS_PC;
				d_opb = OPB_IS_U_IMM;
			end
			2: begin
				inst = {imm[31:12], rd_n, OP_JAL};
				d_dest = 1'b1;
				d_ubr = 1'b1;
				d_opa = OPA_IS_PC;
				d_opb = OPB_IS_J_IMM;
			end
			3: begin
				inst = {imm[31:20], rs1_n, F3_JALR, rd_n, OP_JALR};
				d_dest = 1'b1;
				d_ubr = 1'b1;
				d_opb = OPB_IS_I_IMM;
			end
			4: begin
				inst = {imm[31:25], rs2_n, rs1_n, br_f3[r[31:16] % 6], imm[11:7], OP_BRANCH};
				d_cbr = 1'b1;
				d_opa = OPA_IS_PC;
				d_opb = OPB_IS_B_IMM;
			end
			5: begin
				inst = {imm[31:20], rs1_n, ld_f3[r[31:16] % 5], rd_n, OP_LOAD};
				d_dest = 1'b1;
				d_rdm = 1'b1;
				d_opb = OPB_IS_I_IMM;
			end
			6: begin
				inst = {imm[31:25], rs2_n, rs1_n, st_f3[r[31:16] % 3], imm[11:7], OP_STORE};
				d_wrm = 1'b1;
				d_opb = OPB_IS_S_IMM;
			end
			7: begin
				pick_int_op(int'(r[31:16] % 9), f3, f7, d_alu);
				if (f3 == F3_SLL || f3 == F3_SR)
					inst = {f7, imm[24:20], rs1_n, f3, rd_n, OP_IMM};
				else
					inst = {imm[31:20], rs1_n, f3, rd_n, OP_IMM};
				d_dest = 1'b1;
				d_opb = OPB_IS_I_IMM;
			end
			8, 12: begin
				pick_int_op(int'(r[31:16] % 14), f3, f7, d_alu);
				inst = {f7, rs2_n, rs1_n, f3, rd_n, OP_REG};
				d_dest = 1'b1;
			end
			9: begin
				inst = {imm[31:20], rs1_n, csr_f3[r[31:16] % 3], rd_n, OP_SYSTEM};
				d_csr = 1'b1;
			end
			10: begin
				inst = WFI_INST;
				d_halt = 1'b1;
			end
			default: begin
				inst = {imm[31:7], 7'b1111111};  // no such opcode
				d_ill = 1'b1;
			end
		endcase
		inst_valid = (r[15:13] != 3'd0);
		pc = {imm[29:0], 2'b00};
	endtask

	task automatic drive_events();
		logic [31:0] r;
		reg_idx_t k;
		r = next_rand();
		rob_full = (r[2:0] == 3'd0);
		rs_full = {r[5:3] == 3'd0, r[8:6] == 3'd0};
		k = {2'b00, r[11:9]};
		cdb_valid = (r[13:12] == 2'd0);
		cdb_tag = m_busy[k] ? m_tag[k] : r[16 +: TAG_W];
		r = next_rand();
		commit_en = (r[1:0] == 2'd0);
		commit_idx = {2'b00, r[4:2]};
		// half the commits name the current producer, the rest a stale tag
		commit_tag = (m_busy[commit_idx] && r[5]) ? m_tag[commit_idx] : r[8 +: TAG_W];
		commit_data = next_rand() ^ {r[23:0], 8'h5a};
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout after %0d cycles without finishing the test", cycles);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic was_dispatch, was_stall;
		inst = '0;
		inst_valid = 1'b0;
		pc = '0;
		rob_full = 1'b0;
		rob_tail_tag = '0;
		rs_full = 2'b00;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		commit_en = 1'b0;
		commit_idx = '0;
		commit_data = '0;
		commit_tag = '0;
		d_opa = OPA_IS_RS1;
		d_opb = OPB_IS_RS2;
		d_alu = ALU_ADD;
		{d_dest, d_rdm, d_wrm, d_cbr, d_ubr, d_csr, d_halt, d_ill} = '0;
		@(negedge reset);
		for (int n = 0; n < NUM_CYCLES; n++) begin
			@(negedge clock);
			was_dispatch = exp_dispatch;
			was_stall = exp_stall;
			@(posedge clock);
			#1;
			if (was_dispatch)
				rob_tail_tag = rob_tail_tag + 1'b1;
			if (!was_stall)
				build_inst();  // a stalled inst is held as fetch would
			drive_events();
		end
		repeat (2) @(posedge clock);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter real PERIOD      = 8.0,
	parameter int  RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;  // released with the rest of the inputs
	end

endmodule

//--- logic/issue_stage.sv
`timescale 1ns/10ps

module issue_stage import rv_pkg::*; #(
	parameter int TAG_W = DEF_TAG_W
) (
	input  logic             clock,
	input  logic             reset,
	// fetch
	input  inst_t            inst,
	input  logic             inst_valid,
	input  xlen_t            pc,
	// rob
	input  logic             rob_full,
	input  logic [TAG_W-1:0] rob_tail_tag,
	input  xlen_t            rs1_rob_value,
	input  xlen_t            rs2_rob_value,
	// reservation stations
	input  logic [1:0]       rs_full,
	// cdb and commit
	input  logic             cdb_valid,
	input  logic [TAG_W-1:0] cdb_tag,
	input  logic             commit_en,
	input  reg_idx_t         commit_idx,
	input  xlen_t            commit_data,
	input  logic [TAG_W-1:0] commit_tag,
	// decoded controls
	output opa_sel_t         opa_select,
	output opb_sel_t         opb_select,
	output alu_func_t        alu_func,
	output logic             has_dest,
	output logic             rd_mem,
	output logic             wr_mem,
	output logic             cond_branch,
	output logic             uncond_branch,
	output logic             csr_op,
	output logic             halt,
	output logic             illegal,
	output logic             decoded_valid,
	output xlen_t            dispatch_pc,  // travels with the inst to the station
	// operands
	output xlen_t            rs1_value,
	output logic             rs1_ready,
	output logic [TAG_W-1:0] rs1_tag,
	output xlen_t            rs2_value,
	output logic             rs2_ready,
	output logic [TAG_W-1:0] rs2_tag,
	// dispatch
	output fu_sel_t          fu_select,
	output logic             dispatch_en,
	output logic             stall_if,
	output logic [TAG_W-1:0] alloc_tag,
	output logic             alloc_wr_mem,
	output funct3_t          alloc_mem_size,
	output logic             rename_en,
	output reg_idx_t         rename_idx,
	output logic [TAG_W-1:0] rename_tag
);

	assign dispatch_pc = pc;

	decoder decoder_0 (
		.inst          (inst),
		.inst_valid    (inst_valid),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.alu_func      (alu_func),
		.has_dest      (has_dest),
		.rd_mem        (rd_mem),
		.wr_mem        (wr_mem),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.csr_op        (csr_op),
		.halt          (halt),
		.illegal       (illegal),
		.valid         (decoded_valid)
	);

	operand_read #(.TAG_W(TAG_W)) operand_0 (
		.clock         (clock),
		.reset         (reset),
		.rs1_idx       (inst[19:15]),
		.rs2_idx       (inst[24:20]),
		.rs1_rob_value (rs1_rob_value),
		.rs2_rob_value (rs2_rob_value),
		.commit_en     (commit_en),
		.commit_idx    (commit_idx),
		.commit_data   (commit_data),
		.commit_tag    (commit_tag),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.rename_en     (rename_en),
		.rename_idx    (rename_idx),
		.rename_tag    (rename_tag),
		.rs1_value     (rs1_value),
		.rs1_ready     (rs1_ready),
		.rs1_tag       (rs1_tag),
		.rs2_value     (rs2_value),
		.rs2_ready     (rs2_ready),
		.rs2_tag       (rs2_tag)
	);

	dispatch_ctrl #(.TAG_W(TAG_W)) dispatch_0 (
		.valid          (decoded_valid),
		.has_dest       (has_dest),
		.rd_mem         (rd_mem),
		.wr_mem         (wr_mem),
		.rd             (inst[11:7]),
		.funct3         (inst[14:12]),
		.rob_full       (rob_full),
		.rob_tail_tag   (rob_tail_tag),
		.rs_full        (rs_full),
		.fu_select      (fu_select),
		.dispatch_en    (dispatch_en),
		.stall_if       (stall_if),
		.alloc_tag      (alloc_tag),
		.alloc_wr_mem   (alloc_wr_mem),
		.alloc_mem_size (alloc_mem_size),
		.rename_en      (rename_en),
		.rename_idx     (rename_idx),
		.rename_tag     (rename_tag)
	);

endmodule

//--- logic/dispatch_ctrl.sv
`timescale 1ns/10ps

module dispatch_ctrl import rv_pkg::*; #(
	parameter int TAG_W = DEF_TAG_W
) (
	input  logic             valid,     // decoded valid, no halt or illegal
	input  logic             has_dest,
	input  logic             rd_mem,
	input  logic             wr_mem,
	input  reg_idx_t         rd,
	input  funct3_t          funct3,
	input  logic             rob_full,
	input  logic [TAG_W-1:0] rob_tail_tag,
	input  logic [1:0]       rs_full,   // one bit per station class
	output fu_sel_t          fu_select,
	output logic             dispatch_en,
	output logic             stall_if,
	output logic [TAG_W-1:0] alloc_tag,
	output logic             alloc_wr_mem,
	output funct3_t          alloc_mem_size,
	output logic             rename_en,
	output reg_idx_t         rename_idx,
	output logic [TAG_W-1:0] rename_tag
);

	fu_sel_t fu_class;
	logic    class_full;

	// memory ops go to the address unit, all else to the alu stations
	assign fu_class   = (rd_mem || wr_mem) ? FU_ACU : FU_ALU;
	assign class_full = |(rs_full & fu_class);

	assign dispatch_en = valid && !rob_full && !class_full;
	assign stall_if    = valid && (rob_full || class_full);  // fetch holds the inst
	assign fu_select   = dispatch_en ? fu_class : FU_NONE;

	assign alloc_tag      = rob_tail_tag;
	assign alloc_wr_mem   = wr_mem;
	assign alloc_mem_size = funct3;  // byte, half or word plus sign bit

	// stores, branches and writes to x0 keep the old mapping
	assign rename_en  = dispatch_en && has_dest && (rd != ZERO_REG);
	assign rename_idx = rd;
	assign rename_tag = rob_tail_tag;

	always_comb begin
		assert (!(dispatch_en && stall_if))
			else $error("dispatch_ctrl: dispatch and stall in one cycle");
	end

endmodule

//--- logic/operand_read.sv
`timescale 1ns/10ps

module operand_read import rv_pkg::*; #(
	parameter int TAG_W = DEF_TAG_W
) (
	input  logic             clock,
	input  logic             reset,
	input  reg_idx_t         rs1_idx,
	input  reg_idx_t         rs2_idx,
	input  xlen_t            rs1_rob_value,
	input  xlen_t            rs2_rob_value,
	input  logic             commit_en,
	input  reg_idx_t         commit_idx,
	input  xlen_t            commit_data,
	input  logic [TAG_W-1:0] commit_tag,
	input  logic             cdb_valid,
	input  logic [TAG_W-1:0] cdb_tag,
	input  logic             rename_en,
	input  reg_idx_t         rename_idx,
	input  logic [TAG_W-1:0] rename_tag,
	output xlen_t            rs1_value,
	output logic             rs1_ready,
	output logic [TAG_W-1:0] rs1_tag,
	output xlen_t            rs2_value,
	output logic             rs2_ready,
	output logic [TAG_W-1:0] rs2_tag
);

	xlen_t rf_rs1_value, rf_rs2_value;
	logic  rs1_busy, rs2_busy;
	logic  rs1_tag_ready, rs2_tag_ready;

	regfile regf_0 (
		.clock   (clock),
		.rda_idx (rs1_idx),
		.rdb_idx (rs2_idx),
		.rda_out (rf_rs1_value),
		.rdb_out (rf_rs2_value),
		.wr_en   (commit_en),
		.wr_idx  (commit_idx),
		.wr_data (commit_data)
	);

	map_table #(.TAG_W(TAG_W)) map_0 (
		.clock         (clock),
		.reset         (reset),
		.rs1_idx       (rs1_idx),
		.rs2_idx       (rs2_idx),
		.rs1_busy      (rs1_busy),
		.rs1_tag       (rs1_tag),
		.rs1_tag_ready (rs1_tag_ready),
		.rs2_busy      (rs2_busy),
		.rs2_tag       (rs2_tag),
		.rs2_tag_ready (rs2_tag_ready),
		.rename_en     (rename_en),
		.rename_idx    (rename_idx),
		.rename_tag    (rename_tag),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.commit_en     (commit_en),
		.commit_idx    (commit_idx),
		.commit_tag    (commit_tag)
	);

	// renamed source comes from the ROB, value only meaningful once its tag is ready
	assign rs1_value = rs1_busy ? rs1_rob_value : rf_rs1_value;
	assign rs2_value = rs2_busy ? rs2_rob_value : rf_rs2_value;
	assign rs1_ready = !rs1_busy || rs1_tag_ready;
	assign rs2_ready = !rs2_busy || rs2_tag_ready;

endmodule

//--- logic/map_table.sv
`timescale 1ns/10ps

module map_table import rv_pkg::*; #(
	parameter int TAG_W = DEF_TAG_W
) (
	input  logic             clock,
	input  logic             reset,
	input  reg_idx_t         rs1_idx,
	input  reg_idx_t         rs2_idx,
	output logic             rs1_busy,
	output logic [TAG_W-1:0] rs1_tag,
	output logic             rs1_tag_ready,
	output logic             rs2_busy,
	output logic [TAG_W-1:0] rs2_tag,
	output logic             rs2_tag_ready,
	input  logic             rename_en,
	input  reg_idx_t         rename_idx,
	input  logic [TAG_W-1:0] rename_tag,
	input  logic             cdb_valid,
	input  logic [TAG_W-1:0] cdb_tag,
	input  logic             commit_en,
	input  reg_idx_t         commit_idx,
	input  logic [TAG_W-1:0] commit_tag
);

	logic [31:0]      busy;   // register waits on a ROB entry
	logic [31:0]      ready;  // that entry has broadcast its result
	logic [TAG_W-1:0] tag [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy  <= '0;
			ready <= '0;
		end else begin
			for (int i = 0; i < 32; i++) begin
				if (cdb_valid && busy[i] && tag[i] == cdb_tag)
					ready[i] <= 1'b1;
				// only clear if no younger producer has taken over
				if (commit_en && commit_idx == reg_idx_t'(i) && busy[i] &&
				    tag[i] == commit_tag)
					busy[i] <= 1'b0;
				if (rename_en && rename_idx == reg_idx_t'(i)) begin
					busy[i]  <= 1'b1;  // new mapping beats clear and wakeup
					ready[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rename_en)
			tag[rename_idx] <= rename_tag;
	end

	assign rs1_busy      = busy[rs1_idx];
	assign rs1_tag       = tag[rs1_idx];
	assign rs1_tag_ready = ready[rs1_idx];
	assign rs2_busy      = busy[rs2_idx];
	assign rs2_tag       = tag[rs2_idx];
	assign rs2_tag_ready = ready[rs2_idx];

	// dispatch must never hand x0 to a producer
	assert property (@(posedge clock) disable iff (reset) !busy[0])
		else $error("map_table: x0 marked busy");

endmodule

//--- logic/regfile.sv
`timescale 1ns/10ps

module regfile import rv_pkg::*; (
	input  logic     clock,
	input  reg_idx_t rda_idx,
	input  reg_idx_t rdb_idx,
	output xlen_t    rda_out,
	output xlen_t    rdb_out,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  xlen_t    wr_data
);

	xlen_t regs [32] = '{default: '0};  // power-up contents are zero

	// x0 reads as zero whatever the array holds
	assign rda_out = (rda_idx == ZERO_REG) ? '0 : regs[rda_idx];
	assign rdb_out = (rdb_idx == ZERO_REG) ? '0 : regs[rdb_idx];

	always_ff @(posedge clock) begin
		if (wr_en && wr_idx != ZERO_REG)
			regs[wr_idx] <= wr_data;
	end

endmodule

//--- logic/decoder.sv
`timescale 1ns/10ps

module decoder import rv_pkg::*; (
	input  inst_t     inst,
	input  logic      inst_valid,
	output opa_sel_t  opa_select,
	output opb_sel_t  opb_select,
	output alu_func_t alu_func,
	output logic      has_dest,
	output logic      rd_mem,
	output logic      wr_mem,
	output logic      cond_branch,
	output logic      uncond_branch,
	output logic      csr_op,
	output logic      halt,
	output logic      illegal,
	output logic      valid
);

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// halt and illegal both drop the instruction
	assign valid = inst_valid && !illegal && !halt;

	// funct3 to alu op for the base encodings (funct7 zero)
	function automatic alu_func_t base_op(input funct3_t f3);
		case (f3)
			F3_SLL:  base_op = ALU_SLL;
			F3_SLT:  base_op = ALU_SLT;
			F3_SLTU: base_op = ALU_SLTU;
			F3_XOR:  base_op = ALU_XOR;
			F3_SR:   base_op = ALU_SRL;
			F3_OR:   base_op = ALU_OR;
			F3_AND:  base_op = ALU_AND;
			default: base_op = ALU_ADD;
		endcase
	endfunction

	always_comb begin
		// defaults form a no-op
		opa_select    = OPA_IS_RS1;
		opb_select    = OPB_IS_RS2;
		alu_func      = ALU_ADD;
		has_dest      = 1'b0;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;
		if (inst_valid) begin
			case (opcode)
				OP_LUI: begin
					has_dest   = 1'b1;
					opa_select = OPA_IS_ZERO;
					opb_select = OPB_IS_U_IMM;
				end
				OP_AUIPC: begin
					has_dest   = 1'b1;
					opa_select = OPA_IS_PC;
					opb_select = OPB_IS_U_IMM;
				end
				OP_JAL: begin
					has_dest      = 1'b1;
					opa_select    = OPA_IS_PC;
					opb_select    = OPB_IS_J_IMM;
					uncond_branch = 1'b1;
				end
				OP_JALR: begin
					has_dest      = 1'b1;
					opb_select    = OPB_IS_I_IMM;
					uncond_branch = 1'b1;
					illegal       = (funct3 != F3_JALR);
				end
				OP_BRANCH: begin
					opa_select  = OPA_IS_PC;
					opb_select  = OPB_IS_B_IMM;
					cond_branch = 1'b1;
					illegal     = (funct3 == 3'b010) || (funct3 == 3'b011);  // holes
				end
				OP_LOAD: begin
					has_dest   = 1'b1;
					opb_select = OPB_IS_I_IMM;
					rd_mem     = 1'b1;
					illegal    = !(funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
				end
				OP_STORE: begin
					opb_select = OPB_IS_S_IMM;
					wr_mem     = 1'b1;
					illegal    = !(funct3 inside {F3_SB, F3_SH, F3_SW});
				end
				OP_IMM: begin
					has_dest   = 1'b1;
					opb_select = OPB_IS_I_IMM;
					alu_func   = base_op(funct3);
					if (funct3 == F3_SLL)
						illegal = (funct7 != F7_BASE);
					else if (funct3 == F3_SR) begin
						if (funct7 == F7_ALT)
							alu_func = ALU_SRA;
						else
							illegal = (funct7 != F7_BASE);
					end
				end
				OP_REG: begin
					has_dest = 1'b1;
					case (funct7)
						F7_BASE: alu_func = base_op(funct3);
						F7_ALT: begin
							if (funct3 == F3_ADD)
								alu_func = ALU_SUB;
							else if (funct3 == F3_SR)
								alu_func = ALU_SRA;
							else
								illegal = 1'b1;
						end
						F7_MULDIV: begin
							case (funct3)
								F3_MUL:    alu_func = ALU_MUL;
								F3_MULH:   alu_func = ALU_MULH;
								F3_MULHSU: alu_func = ALU_MULHSU;
								F3_MULHU:  alu_func = ALU_MULHU;
								default:   illegal = 1'b1;  // no divider here
							endcase
						end
						default: illegal = 1'b1;
					endcase
				end
				OP_SYSTEM: begin
					if (inst == WFI_INST)
						halt = 1'b1;
					else if (funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC})
						csr_op = 1'b1;
					else
						illegal = 1'b1;  // ecall, ebreak, csr immediates
				end
				default: illegal = 1'b1;
			endcase
		end
	end

	always_comb begin
		assert (!(halt && illegal))
			else $error("decoder: halt and illegal raised together");
	end

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] xlen_t;     // data word
	typedef logic [4:0]  reg_idx_t;  // architectural register index
	typedef logic [31:0] inst_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	localparam int DEF_TAG_W = 3;    // 8-entry ROB by default

	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_SLT    = 4'h2,
		ALU_SLTU   = 4'h3,
		ALU_AND    = 4'h4,
		ALU_OR     = 4'h5,
		ALU_XOR    = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,
		ALU_MULH   = 4'hb,
		ALU_MULHSU = 4'hc,
		ALU_MULHU  = 4'hd
	} alu_func_t;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_PC   = 2'h1,
		OPA_IS_ZERO = 2'h2
	} opa_sel_t;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_sel_t;

	// one-hot class code, bit positions line up with rs_full
	typedef logic [1:0] fu_sel_t;
	localparam fu_sel_t FU_NONE = 2'b00;
	localparam fu_sel_t FU_ALU  = 2'b01;
	localparam fu_sel_t FU_ACU  = 2'b10;  // address unit, loads and stores

	localparam reg_idx_t ZERO_REG = 5'd0;

	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	localparam funct3_t F3_JALR = 3'b000;
	// branches
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;
	// loads and stores, funct3 doubles as the access size
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;
	localparam funct3_t F3_SB  = 3'b000;
	localparam funct3_t F3_SH  = 3'b001;
	localparam funct3_t F3_SW  = 3'b010;
	// integer ops, shared by OP_IMM and OP_REG
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;
	// M extension, multiplies only
	localparam funct3_t F3_MUL    = 3'b000;
	localparam funct3_t F3_MULH   = 3'b001;
	localparam funct3_t F3_MULHSU = 3'b010;
	localparam funct3_t F3_MULHU  = 3'b011;
	// csr access
	localparam funct3_t F3_CSRRW = 3'b001;
	localparam funct3_t F3_CSRRS = 3'b010;
	localparam funct3_t F3_CSRRC = 3'b011;

	localparam funct7_t F7_BASE   = 7'b0000000;
	localparam funct7_t F7_ALT    = 7'b0100000;  // sub, sra, srai
	localparam funct7_t F7_MULDIV = 7'b0000001;

	localparam inst_t WFI_INST = 32'h10500073;

endpackage
